// ==== Makefile ====
# Verilator simulation of the fetch core testbench

VERILATOR ?= verilator
TOP ?= fetchCoreTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/controlDecoder.sv ====
// Instruction decoder; registers the fetched word and produces jump, branch, JR and MULT control
module controlDecoder (
	input logic clock,
	input logic sync_reset,
	input fetchPkg::word_t instr,
	input fetchPkg::word_t rsValue,
	input fetchPkg::word_t rtValue,
	input fetchPkg::addr_t fetchAddr,
	input logic hold,
	output fetchPkg::ctrl_t ctrl
);

	// Word on the bus this cycle
	fetchPkg::addr_t busAddr;
	logic busLive;

	// Decode stage
	fetchPkg::word_t instrReg;
	fetchPkg::addr_t instrAddr;
	fetchPkg::word_t rsReg;
	logic operandsEqual;
	logic decValid;
	fetchPkg::op_t opcode;
	fetchPkg::op_t funct;
	logic isJump;
	logic isBeq;
	logic isBne;
	logic isJr;
	logic isMult;
	fetchPkg::addr_t seqAddr;
	fetchPkg::addr_t branchOffset;
	fetchPkg::addr_t branchTarget;

	// Resolve stage
	logic branchTakenReg;
	logic regJumpReg;
	fetchPkg::addr_t branchTargetReg;
	fetchPkg::addr_t regTargetReg;

	// A word is live only if the previous cycle was a real fetch
	always_ff @(posedge clock) begin
		if (sync_reset) begin
			busLive <= 1'b0;
		end else begin
			busLive <= ~hold;
		end
	end

	always_ff @(posedge clock) begin
		busAddr <= fetchAddr; // Lines up with the word next cycle
	end

	always_ff @(posedge clock) begin
		if (sync_reset) begin
			decValid <= 1'b0;
		end else begin
			decValid <= busLive;
		end
	end

	always_ff @(posedge clock) begin
		instrReg <= instr;
		instrAddr <= busAddr;
		rsReg <= rsValue;
		operandsEqual <= (rsValue == rtValue);
	end

	assign opcode = instrReg[31:26];
	assign funct = instrReg[5:0];

	assign isJump = decValid && (opcode == fetchPkg::OpJ);
	assign isBeq = decValid && (opcode == fetchPkg::OpBeq);
	assign isBne = decValid && (opcode == fetchPkg::OpBne);
	assign isJr = decValid && (opcode == fetchPkg::OpSpecial) && (funct == fetchPkg::FnJr);
	assign isMult = decValid && (opcode == fetchPkg::OpSpecial) && (funct == fetchPkg::FnMult);

	// Branch target relative to the delay slot
	assign seqAddr = instrAddr + fetchPkg::addr_t'(fetchPkg::PcStep);
	assign branchOffset = {{(fetchPkg::AddrWidth - 18){instrReg[15]}}, instrReg[15:0], 2'b00};
	assign branchTarget = seqAddr + branchOffset;

	always_ff @(posedge clock) begin
		if (sync_reset) begin
			branchTakenReg <= 1'b0;
			regJumpReg <= 1'b0;
		end else begin
			branchTakenReg <= (isBeq && operandsEqual) || (isBne && !operandsEqual);
			regJumpReg <= isJr;
		end
	end

	always_ff @(posedge clock) begin
		branchTargetReg <= branchTarget;
		regTargetReg <= rsReg[fetchPkg::AddrWidth-1:0]; // Truncated register target
	end

	// J and MULT leave from the decode stage, branch and JR one stage later
	always_comb begin
		ctrl.jumpValid = isJump;
		ctrl.jumpTarget = {instrReg[fetchPkg::AddrWidth-3:0], 2'b00};
		ctrl.branchTaken = branchTakenReg;
		ctrl.branchTarget = branchTargetReg;
		ctrl.regJumpValid = regJumpReg;
		ctrl.regTarget = regTargetReg;
		ctrl.mulStart = isMult;
	end

endmodule

// ==== hdl/fetchCore.sv ====
// Fetch core top; wires decoder, multiply sequencer and PC unit to one fetch port
module fetchCore (
	input logic clock,
	input logic sync_reset,
	input fetchPkg::word_t instr,
	input fetchPkg::word_t rsValue,
	input fetchPkg::word_t rtValue,
	output fetchPkg::addr_t fetchAddr,
	output logic stall
);

	fetchPkg::ctrl_t ctrl;
	fetchPkg::addr_t savedAddr;
	logic hold;

	controlDecoder i_controlDecoder (
		.clock(clock),
		.sync_reset(sync_reset),
		.instr(instr),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.fetchAddr(fetchAddr),
		.hold(hold),
		.ctrl(ctrl)
	);

	mulDivSequencer i_mulDivSequencer (
		.clock(clock),
		.sync_reset(sync_reset),
		.mulStart(ctrl.mulStart),
		.fetchAddr(fetchAddr),
		.hold(hold),
		.savedAddr(savedAddr)
	);

	pcUnit i_pcUnit (
		.clock(clock),
		.sync_reset(sync_reset),
		.ctrl(ctrl),
		.hold(hold),
		.savedAddr(savedAddr),
		.fetchAddr(fetchAddr)
	);

	assign stall = hold; // Multiply busy

endmodule

// ==== hdl/fetchPkg.sv ====
// Shared types, opcodes and constants for the fetch core; referenced by scoped names
package fetchPkg;

	localparam int AddrWidth = 26;
	localparam int WordWidth = 32;
	localparam int OpWidth = 6;
	localparam int PcStep = 4; // Bytes per instruction

	typedef logic [AddrWidth-1:0] addr_t; // Byte address
	typedef logic [WordWidth-1:0] word_t;
	typedef logic [OpWidth-1:0] op_t;

	// Primary opcodes in bits 31:26
	localparam op_t OpSpecial = 6'h00;
	localparam op_t OpJ = 6'h02;
	localparam op_t OpBeq = 6'h04;
	localparam op_t OpBne = 6'h05;

	// Function codes under OpSpecial in bits 5:0
	localparam op_t FnJr = 6'h08;
	localparam op_t FnMult = 6'h18;

	localparam int MulDivCycles = 6; // Cycles that fetch is held
	localparam int CountWidth = $clog2(MulDivCycles);

	typedef logic [CountWidth-1:0] count_t;

	typedef struct packed {
		logic jumpValid;
		addr_t jumpTarget;
		logic branchTaken;
		addr_t branchTarget;
		logic regJumpValid;
		addr_t regTarget;
		logic mulStart;
	} ctrl_t;

	typedef enum logic {
		Idle,
		Busy
	} seq_state_t;

endpackage

// ==== hdl/mulDivSequencer.sv ====
// Multiply stall sequencer; holds fetch on a fixed address while a MULT is busy
module mulDivSequencer (
	input logic clock,
	input logic sync_reset,
	input logic mulStart,
	input fetchPkg::addr_t fetchAddr,
	output logic hold,
	output fetchPkg::addr_t savedAddr
);

	fetchPkg::seq_state_t state;
	fetchPkg::count_t count;
	fetchPkg::addr_t lastAddr; // Last address fetched before the hold
	logic start;

	assign start = mulStart && (state == fetchPkg::Idle);
	assign hold = start || (state == fetchPkg::Busy); // Hold starts with the pulse

	always_ff @(posedge clock) begin
		if (sync_reset) begin
			state <= fetchPkg::Idle;
			count <= '0;
		end else begin
			case (state)
				fetchPkg::Idle: begin
					if (mulStart) begin
						state <= fetchPkg::Busy;
						count <= fetchPkg::count_t'(fetchPkg::MulDivCycles - 1);
					end
				end
				fetchPkg::Busy: begin
					count <= count - 1'b1;
					if (count == fetchPkg::count_t'(1)) begin
						state <= fetchPkg::Idle; // Release hold
					end
				end
				default: state <= fetchPkg::Idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			lastAddr <= fetchAddr;
		end
	end

	// Held address is the one after the last live fetch
	assign savedAddr = lastAddr + fetchPkg::addr_t'(fetchPkg::PcStep);

endmodule

// ==== hdl/pcUnit.sv ====
// Program counter; picks the fetch address each cycle from hold, redirects and increment
module pcUnit (
	input logic clock,
	input logic sync_reset,
	input fetchPkg::ctrl_t ctrl,
	input logic hold,
	input fetchPkg::addr_t savedAddr,
	output fetchPkg::addr_t fetchAddr
);

	fetchPkg::addr_t pcReg; // Address to fetch when nothing else applies
	fetchPkg::addr_t redirectAddr;
	fetchPkg::addr_t nextPc;
	logic lateRedirect;
	logic redirect;

	// Branch and JR resolve one stage after J, so they win over it
	always_comb begin
		lateRedirect = ctrl.branchTaken | ctrl.regJumpValid;
		redirect = lateRedirect | ctrl.jumpValid;
	end

	always_comb begin
		if (ctrl.branchTaken) begin
			redirectAddr = ctrl.branchTarget;
		end else if (lateRedirect) begin
			redirectAddr = ctrl.regTarget; // JR
		end else begin
			redirectAddr = ctrl.jumpTarget;
		end
	end

	// Redirect overrides the address in the cycle it becomes valid
	always_comb begin
		if (hold) begin
			fetchAddr = savedAddr; // Frozen during multiply
		end else if (redirect) begin
			fetchAddr = redirectAddr;
		end else begin
			fetchAddr = pcReg;
		end
	end

	// Under hold savedAddr is constant, so pcReg stays put
	assign nextPc = fetchAddr + fetchPkg::addr_t'(fetchPkg::PcStep);

	always_ff @(posedge clock) begin
		if (sync_reset) begin
			pcReg <= '0;
		end else begin
			pcReg <= nextPc;
		end
	end

endmodule

// ==== project.f ====
hdl/fetchPkg.sv
hdl/pcUnit.sv
hdl/controlDecoder.sv
hdl/mulDivSequencer.sv
hdl/fetchCore.sv
tb/fetchCoreTb.sv

// ==== tb/fetchCoreTb.sv ====
// Testbench for the fetch core; acts as instruction memory and checks the fetch address trace
module fetchCoreTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MemWords = 64; // Byte addresses 0x00 to 0xFC
	localparam int ProgLen = 8;
	localparam int TraceLen = 43;
	localparam int CycleLimit = TraceLen + 20;
	localparam fetchPkg::op_t NopOpcode = 6'h09; // ADDIU is never a control transfer

	typedef struct packed {
		fetchPkg::addr_t addr;
		fetchPkg::word_t instr;
		fetchPkg::word_t rs;
		fetchPkg::word_t rt;
	} prog_entry_t;

	typedef struct packed {
		fetchPkg::addr_t addr;
		logic stall;
	} trace_entry_t;

	logic clock = 1'b0;
	logic sync_reset;
	fetchPkg::word_t instr;
	fetchPkg::word_t rsValue;
	fetchPkg::word_t rtValue;
	fetchPkg::addr_t fetchAddr;
	logic stall;

	fetchPkg::word_t memInstr [MemWords];
	fetchPkg::word_t memRs [MemWords];
	fetchPkg::word_t memRt [MemWords];
	prog_entry_t progTable [ProgLen];
	trace_entry_t expTrace [TraceLen];

	int seed;
	int errorCount;
	int cycleCount = 0;
	fetchPkg::addr_t seenAddr;

	fetchCore i_fetchCore (
		.clock(clock),
		.sync_reset(sync_reset),
		.instr(instr),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.fetchAddr(fetchAddr),
		.stall(stall)
	);

	always #2 clock = ~clock; // 4 ns period

	// Instruction encoders
	function automatic fetchPkg::word_t jumpWord(input fetchPkg::addr_t target);
		jumpWord = {fetchPkg::OpJ, 2'b00, target[fetchPkg::AddrWidth-1:2]};
	endfunction

	function automatic fetchPkg::word_t branchWord(input fetchPkg::op_t op, input logic [15:0] offset);
		branchWord = {op, 5'd1, 5'd2, offset};
	endfunction

	function automatic fetchPkg::word_t jrWord();
		jrWord = {fetchPkg::OpSpecial, 5'd31, 15'd0, fetchPkg::FnJr};
	endfunction

	function automatic fetchPkg::word_t multWord();
		multWord = {fetchPkg::OpSpecial, 5'd1, 5'd2, 10'd0, fetchPkg::FnMult};
	endfunction

	task automatic stopRun();
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] observed,
			input logic [31:0] expected);
		if (observed !== expected) begin
			errorCount++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, name, observed, expected);
			stopRun();
		end
	endtask

	// Random non-control words everywhere the program does not place an instruction
	task automatic fillMemory();
		fetchPkg::word_t filler;
		for (int i = 0; i < MemWords; i++) begin
			filler = $random(seed);
			memInstr[i] = {NopOpcode, filler[25:0]};
			memRs[i] = $random(seed);
			memRt[i] = $random(seed);
		end
	endtask

	task automatic loadProgram();
		progTable[0] = '{26'h010, jumpWord(26'h040), 32'h0, 32'h0};
		progTable[1] = '{26'h048, branchWord(fetchPkg::OpBeq, 16'd13), 32'h12345678, 32'h12345678};
		progTable[2] = '{26'h088, branchWord(fetchPkg::OpBne, 16'h0010), 32'hA5A50001, 32'hA5A50001};
		progTable[3] = '{26'h094, branchWord(fetchPkg::OpBeq, 16'hFFF0), 32'h1, 32'h2};
		progTable[4] = '{26'h0A0, branchWord(fetchPkg::OpBne, 16'hFFDF), 32'h10, 32'h80000010};
		progTable[5] = '{26'h028, jrWord(), 32'hFC0000C0, 32'h0}; // Upper bits drop off
		progTable[6] = '{26'h0C4, multWord(), 32'h3, 32'h7};
		progTable[7] = '{26'h0D8, jumpWord(26'h060), 32'h0, 32'h0};
		for (int i = 0; i < ProgLen; i++) begin
			memInstr[progTable[i].addr[7:2]] = progTable[i].instr;
			memRs[progTable[i].addr[7:2]] = progTable[i].rs;
			memRt[progTable[i].addr[7:2]] = progTable[i].rt;
		end
	endtask

	task automatic buildTrace();
		expTrace[0] = '{26'h000, 1'b0}; // Sequential from reset
		expTrace[1] = '{26'h004, 1'b0};
		expTrace[2] = '{26'h008, 1'b0};
		expTrace[3] = '{26'h00C, 1'b0};
		expTrace[4] = '{26'h010, 1'b0}; // J
		expTrace[5] = '{26'h014, 1'b0};
		expTrace[6] = '{26'h040, 1'b0};
		expTrace[7] = '{26'h044, 1'b0};
		expTrace[8] = '{26'h048, 1'b0}; // Forward BEQ taken
		expTrace[9] = '{26'h04C, 1'b0};
		expTrace[10] = '{26'h050, 1'b0};
		expTrace[11] = '{26'h080, 1'b0};
		expTrace[12] = '{26'h084, 1'b0};
		expTrace[13] = '{26'h088, 1'b0}; // BNE not taken
		expTrace[14] = '{26'h08C, 1'b0};
		expTrace[15] = '{26'h090, 1'b0};
		expTrace[16] = '{26'h094, 1'b0}; // BEQ not taken
		expTrace[17] = '{26'h098, 1'b0};
		expTrace[18] = '{26'h09C, 1'b0};
		expTrace[19] = '{26'h0A0, 1'b0}; // Backward BNE taken
		expTrace[20] = '{26'h0A4, 1'b0};
		expTrace[21] = '{26'h0A8, 1'b0};
		expTrace[22] = '{26'h020, 1'b0};
		expTrace[23] = '{26'h024, 1'b0};
		expTrace[24] = '{26'h028, 1'b0}; // JR
		expTrace[25] = '{26'h02C, 1'b0};
		expTrace[26] = '{26'h030, 1'b0};
		expTrace[27] = '{26'h0C0, 1'b0};
		expTrace[28] = '{26'h0C4, 1'b0}; // MULT
		expTrace[29] = '{26'h0C8, 1'b0};
		expTrace[30] = '{26'h0CC, 1'b1};
		expTrace[31] = '{26'h0CC, 1'b1};
		expTrace[32] = '{26'h0CC, 1'b1};
		expTrace[33] = '{26'h0CC, 1'b1};
		expTrace[34] = '{26'h0CC, 1'b1};
		expTrace[35] = '{26'h0CC, 1'b1};
		expTrace[36] = '{26'h0D0, 1'b0};
		expTrace[37] = '{26'h0D4, 1'b0};
		expTrace[38] = '{26'h0D8, 1'b0}; // J back down
		expTrace[39] = '{26'h0DC, 1'b0};
		expTrace[40] = '{26'h060, 1'b0};
		expTrace[41] = '{26'h064, 1'b0};
		expTrace[42] = '{26'h068, 1'b0};
	endtask

	// Memory read one cycle after the address
	task automatic driveFetch(input fetchPkg::addr_t addr);
		if (addr >= fetchPkg::addr_t'(MemWords * 4) || addr[1:0] != 2'b00) begin
			$display("Fetch address %h lies outside the program memory", addr);
			stopRun();
		end else begin
			instr = memInstr[addr[7:2]];
			rsValue = memRs[addr[7:2]];
			rtValue = memRt[addr[7:2]];
		end
	endtask

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > CycleLimit) begin
			$display("Timeout: the trace did not finish within %0d cycles", CycleLimit);
			stopRun();
		end
	end

	initial begin
		seed = 32'h3f85e6d4;
		errorCount = 0;
		sync_reset = 1'b1;
		instr = '0;
		rsValue = '0;
		rtValue = '0;
		seenAddr = '0;
		fillMemory();
		loadProgram();
		buildTrace();
		repeat (2) @(posedge clock);
		#1;
		sync_reset = 1'b0;
		for (int cycle = 0; cycle < TraceLen; cycle++) begin
			@(negedge clock); // Outputs settled mid-cycle
			checkValue("fetchAddr", 32'(fetchAddr), 32'(expTrace[cycle].addr));
			checkValue("stall", 32'(stall), 32'(expTrace[cycle].stall));
			seenAddr = fetchAddr;
			@(posedge clock);
			#1;
			driveFetch(seenAddr);
		end
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stopRun();
		end
	end

endmodule
